// File: hdl/osd_params.svh
// register map addresses, character memory geometry and reset pulse length
`ifndef OSD_PARAMS_SVH
`define OSD_PARAMS_SVH

//////////////////////////////
// register map
//////////////////////////////

// page offset for character writes, everything below this address is char data
`define OSD_REG_OFFSET     8'h80
`define OSD_REG_ENABLE     8'h81
`define OSD_REG_HIGHLIGHT  8'h82
// video mode select, low nibble picks the timing
`define OSD_REG_RECONF     8'h83
// controller buttons, read only
`define OSD_REG_CTRL_HI    8'h85
`define OSD_REG_CTRL_LO    8'h86
// scanline settings, split over two bytes
`define OSD_REG_SCAN_HI    8'h87
`define OSD_REG_SCAN_LO    8'h88
// reset triggers, write only
`define OSD_REG_RESET_DC   8'hF0
`define OSD_REG_RESET_OPT  8'hF1
`define OSD_REG_RESET_CONF 8'hF2

//////////////////////////////
// character memory and resets
//////////////////////////////

// 3 page bits on top of 7 low address bits
`define OSD_RAM_AW         10
`define OSD_RAM_DEPTH      (1 << `OSD_RAM_AW)
// cycles a console or optical reset stays asserted
`define RESET_HOLD_CYCLES  16

`endif

// File: hdl/osd_pkg.sv
// controller, scanline and video timing types plus the four video mode constants
package osd_pkg;

    // button state from the game controller, a in the top bit
    typedef struct packed {
        logic a;
        logic b;
        logic x;
        logic y;
        logic up;
        logic down;
        logic left;
        logic right;
        logic start;
        logic ltrigger;
        logic rtrigger;
        logic trigger_osd;
        logic trigger_default_resolution;
    } controller_data_t;

    // scanline overlay settings
    typedef struct packed {
        logic [8:0] intensity;
        logic       thickness;
        logic       oddeven;
        logic       active;
    } scanline_t;

    // video timing handed to the output pipeline
    typedef struct packed {
        logic [11:0] h_active;
        logic [10:0] v_active;
        logic [11:0] h_total;
        logic [10:0] v_total;
        logic [7:0]  vic;
    } video_config_t;

    //////////////////////////////
    // supported output modes
    //////////////////////////////

    localparam video_config_t mode_1080p = '{
        h_active: 12'd1920,
        v_active: 11'd1080,
        h_total:  12'd2200,
        v_total:  11'd1125,
        vic:      8'd16
    };

    // no standard vic for this one
    localparam video_config_t mode_960p = '{
        h_active: 12'd1280,
        v_active: 11'd960,
        h_total:  12'd1800,
        v_total:  11'd1000,
        vic:      8'd0
    };

    localparam video_config_t mode_480p = '{
        h_active: 12'd720,
        v_active: 11'd480,
        h_total:  12'd858,
        v_total:  11'd525,
        vic:      8'd2
    };

    localparam video_config_t mode_vga = '{
        h_active: 12'd640,
        v_active: 11'd480,
        h_total:  12'd800,
        v_total:  11'd525,
        vic:      8'd1
    };

endpackage

// File: hdl/osd_reg_file.sv
// register decoder with configuration registers, registered read mux and strobes
`include "osd_params.svh"

module osd_reg_file (
    input  logic                      clk,
    input  logic                      arst_n,
    // byte bus from the serial slave
    input  logic [7:0]                addr,
    input  logic [7:0]                data_in,
    input  logic                      write_en,
    output logic [7:0]                data_out,
    input  osd_pkg::controller_data_t controller_data,
    // character write port
    output logic                      ram_wren,
    output logic [`OSD_RAM_AW-1:0]    ram_waddr,
    output logic [7:0]                ram_wdata,
    // configuration outputs
    output logic                      enable_osd,
    output logic [7:0]                highlight_line,
    output logic [7:0]                reconf_data,
    output osd_pkg::scanline_t        scanline,
    output logic [7:0]                reset_conf,
    // one cycle reset triggers
    output logic                      reset_dc_strobe,
    output logic                      reset_opt_strobe
);

    import osd_pkg::*;

    // intensity at half scale, all flags off
    localparam scanline_t scanline_reset = '{
        intensity: 9'h100,
        thickness: 1'b0,
        oddeven:   1'b0,
        active:    1'b0
    };

    // page select for character writes
    logic [2:0] addr_offset;
    logic       char_write;

    // anything below the register window is character data
    assign char_write = write_en && (addr < `OSD_REG_OFFSET);

    //////////////////////////////
    // write side
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_offset    <= 3'd0;
            enable_osd     <= 1'b0;
            highlight_line <= 8'hff;
            reconf_data    <= 8'h00;
            scanline       <= scanline_reset;
            reset_conf     <= 8'h00;
        end else if (write_en) begin
            case (addr)
                `OSD_REG_OFFSET: begin
                    addr_offset <= data_in[2:0];
                end
                `OSD_REG_ENABLE: begin
                    enable_osd <= data_in[0];
                end
                `OSD_REG_HIGHLIGHT: begin
                    highlight_line <= data_in;
                end
                // mode table picks this up one cycle later
                `OSD_REG_RECONF: begin
                    reconf_data <= data_in;
                end
                // upper eight intensity bits
                `OSD_REG_SCAN_HI: begin
                    scanline.intensity[8:1] <= data_in;
                end
                // intensity lsb and flags in the top nibble
                `OSD_REG_SCAN_LO: begin
                    scanline.intensity[0] <= data_in[7];
                    scanline.thickness    <= data_in[6];
                    scanline.oddeven      <= data_in[5];
                    scanline.active       <= data_in[4];
                end
                `OSD_REG_RESET_CONF: begin
                    reset_conf <= data_in;
                end
                default: begin
                    // char writes and reset triggers handled below
                end
            endcase
        end
    end

    // single cycle strobes, never held across back to back writes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_wren         <= 1'b0;
            reset_dc_strobe  <= 1'b0;
            reset_opt_strobe <= 1'b0;
        end else begin
            ram_wren         <= char_write;
            reset_dc_strobe  <= write_en && (addr == `OSD_REG_RESET_DC);
            reset_opt_strobe <= write_en && (addr == `OSD_REG_RESET_OPT);
        end
    end

    // char address and data, aligned with ram_wren
    always_ff @(posedge clk) begin
        if (char_write) begin
            ram_waddr <= {addr_offset, addr[6:0]};
            ram_wdata <= data_in;
        end
    end

    //////////////////////////////
    // read side
    //////////////////////////////

    // data_out follows the address of the previous edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= 8'h00;
        end else begin
            case (addr)
                `OSD_REG_OFFSET:     data_out <= {5'b00000, addr_offset};
                `OSD_REG_ENABLE:     data_out <= {7'b0000000, enable_osd};
                `OSD_REG_HIGHLIGHT:  data_out <= highlight_line;
                `OSD_REG_RECONF:     data_out <= reconf_data;
                // a down to right
                `OSD_REG_CTRL_HI:    data_out <= controller_data[12:5];
                // start down to trigger_default_resolution, zero padded
                `OSD_REG_CTRL_LO:    data_out <= {controller_data[4:0], 3'b000};
                `OSD_REG_SCAN_HI:    data_out <= scanline.intensity[8:1];
                `OSD_REG_SCAN_LO: begin
                    data_out <= {scanline.intensity[0], scanline.thickness,
                                 scanline.oddeven, scanline.active, 4'b0000};
                end
                `OSD_REG_RESET_CONF: data_out <= reset_conf;
                // char memory and reset triggers are write only
                default:             data_out <= 8'h00;
            endcase
        end
    end

endmodule

// File: hdl/video_mode_rom.sv
// registered lookup from the mode select nibble to a video timing configuration
module video_mode_rom (
    input  logic                   clk,
    input  logic                   arst_n,
    // stored reconfiguration byte from the decoder
    input  logic [7:0]             reconf_data,
    output osd_pkg::video_config_t video_config
);

    import osd_pkg::*;

    // only the low nibble selects a mode
    logic [3:0] mode_idx;

    assign mode_idx = reconf_data[3:0];

    //////////////////////////////
    // mode table
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            video_config <= mode_1080p;
        end else begin
            case (mode_idx)
                4'd0: begin
                    video_config <= mode_1080p;
                end
                4'd1: begin
                    video_config <= mode_960p;
                end
                4'd2: begin
                    video_config <= mode_480p;
                end
                4'd3: begin
                    video_config <= mode_vga;
                end
                default: begin
                    // unknown index, keep running on the last good mode
                    video_config <= video_config;
                end
            endcase
        end
    end

endmodule

// File: hdl/osd_char_ram.sv
// simple dual-port OSD character memory with registered read
`include "osd_params.svh"

module osd_char_ram (
    input  logic                   clk,
    // write port, driven by the register decoder
    input  logic                   wren,
    input  logic [`OSD_RAM_AW-1:0] waddr,
    input  logic [7:0]             wdata,
    // read port for the renderer
    input  logic [`OSD_RAM_AW-1:0] rd_addr,
    output logic [7:0]             rd_data
);

    // one byte per character cell
    logic [7:0] mem [0:`OSD_RAM_DEPTH-1];

    //////////////////////////////
    // ports
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
    end

    // read data one cycle after rd_addr
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hdl/reset_pulse_gen.sv
// stretches a one cycle reset strobe into a fixed length pulse
`include "osd_params.svh"

module reset_pulse_gen (
    input  logic clk,
    input  logic arst_n,
    // single cycle request from the decoder
    input  logic strobe,
    output logic pulse
);

    // wide enough to hold the full count
    localparam int cnt_w = $clog2(`RESET_HOLD_CYCLES + 1);

    localparam logic [cnt_w-1:0] hold_count = cnt_w'(`RESET_HOLD_CYCLES);

    logic [cnt_w-1:0] count;

    //////////////////////////////
    // hold counter
    //////////////////////////////

    // a strobe mid pulse restarts the full hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (strobe) begin
            count <= hold_count;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high for exactly hold_count cycles after the strobe
    assign pulse = (count != '0);

endmodule

// File: hdl/osd_ctrl_top.sv
// OSD configuration subsystem top: decoder, mode table, char memory, reset stretchers
`include "osd_params.svh"

module osd_ctrl_top (
    input  logic                      clk,
    input  logic                      arst_n,
    // byte bus from the serial slave
    input  logic [7:0]                addr,
    input  logic [7:0]                data_in,
    input  logic                      write_en,
    output logic [7:0]                data_out,
    // renderer read port
    input  logic [`OSD_RAM_AW-1:0]    osd_rd_addr,
    output logic [7:0]                osd_rd_data,
    input  osd_pkg::controller_data_t controller_data,
    // character write activity
    output logic                      ram_wren,
    output logic [`OSD_RAM_AW-1:0]    ram_waddr,
    output logic [7:0]                ram_wdata,
    // configuration
    output logic                      enable_osd,
    output logic [7:0]                highlight_line,
    output logic [7:0]                reconf_data,
    output osd_pkg::scanline_t        scanline,
    output logic [7:0]                reset_conf,
    output osd_pkg::video_config_t    video_config,
    // stretched resets
    output logic                      reset_dc,
    output logic                      reset_opt
);

    logic reset_dc_strobe;
    logic reset_opt_strobe;

    //////////////////////////////
    // register decoder
    //////////////////////////////

    osd_reg_file u_reg_file (
        .clk              (clk),
        .arst_n           (arst_n),
        .addr             (addr),
        .data_in          (data_in),
        .write_en         (write_en),
        .data_out         (data_out),
        .controller_data  (controller_data),
        .ram_wren         (ram_wren),
        .ram_waddr        (ram_waddr),
        .ram_wdata        (ram_wdata),
        .enable_osd       (enable_osd),
        .highlight_line   (highlight_line),
        .reconf_data      (reconf_data),
        .scanline         (scanline),
        .reset_conf       (reset_conf),
        .reset_dc_strobe  (reset_dc_strobe),
        .reset_opt_strobe (reset_opt_strobe)
    );

    // mode table, one more register stage after reconf_data
    video_mode_rom u_mode_rom (
        .clk          (clk),
        .arst_n       (arst_n),
        .reconf_data  (reconf_data),
        .video_config (video_config)
    );

    osd_char_ram u_char_ram (
        .clk     (clk),
        .wren    (ram_wren),
        .waddr   (ram_waddr),
        .wdata   (ram_wdata),
        .rd_addr (osd_rd_addr),
        .rd_data (osd_rd_data)
    );

    //////////////////////////////
    // reset stretchers
    //////////////////////////////

    // console side
    reset_pulse_gen u_reset_dc (
        .clk    (clk),
        .arst_n (arst_n),
        .strobe (reset_dc_strobe),
        .pulse  (reset_dc)
    );

    // optical side
    reset_pulse_gen u_reset_opt (
        .clk    (clk),
        .arst_n (arst_n),
        .strobe (reset_opt_strobe),
        .pulse  (reset_opt)
    );

endmodule

// File: dv/osd_ctrl_properties.sv
// bound assertions on character write strobes, reset pulse length and unmapped reads
`include "osd_params.svh"

module osd_ctrl_properties (
    input logic       clk,
    input logic       arst_n,
    input logic [7:0] addr,
    input logic       write_en,
    input logic [7:0] data_out,
    input logic       ram_wren,
    input logic       reset_dc,
    input logic       reset_opt
);

    timeunit 1ns;
    timeprecision 100ps;

    // length of the current high run of each reset output
    logic [7:0] dc_len;
    logic [7:0] opt_len;
    logic       mapped;
    // failures seen by the assertions below
    int         fail_count = 0;

    // addresses that return stored data
    assign mapped = addr inside {`OSD_REG_OFFSET, `OSD_REG_ENABLE, `OSD_REG_HIGHLIGHT,
                                 `OSD_REG_RECONF, `OSD_REG_CTRL_HI, `OSD_REG_CTRL_LO,
                                 `OSD_REG_SCAN_HI, `OSD_REG_SCAN_LO, `OSD_REG_RESET_CONF};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dc_len  <= 8'd0;
            opt_len <= 8'd0;
        end else begin
            dc_len  <= reset_dc ? dc_len + 8'd1 : 8'd0;
            opt_len <= reset_opt ? opt_len + 8'd1 : 8'd0;
        end
    end

    //////////////////////////////
    // assertions
    //////////////////////////////

    // char strobe exactly one cycle after a low write
    a_ram_wren: assert property (@(posedge clk) disable iff (!arst_n)
        ram_wren == $past(write_en && (addr < `OSD_REG_OFFSET)))
        else begin
            $error("ram_wren without a preceding character write");
            fail_count++;
        end

    // run length checked on the falling edge of each pulse
    a_pulse_len: assert property (@(posedge clk) disable iff (!arst_n)
        (!$fell(reset_dc) || dc_len == 8'(`RESET_HOLD_CYCLES)) &&
        (!$fell(reset_opt) || opt_len == 8'(`RESET_HOLD_CYCLES)))
        else begin
            $error("reset pulse length differs from the hold count");
            fail_count++;
        end

    a_unmapped_read: assert property (@(posedge clk) disable iff (!arst_n)
        !$past(mapped) |-> data_out == 8'h00)
        else begin
            $error("unmapped address returned nonzero read data");
            fail_count++;
        end

endmodule

// File: dv/osd_ctrl_tb.sv
// testbench for osd_ctrl_top: clock, reset, LFSR, reference model, tests and summary
`include "osd_params.svh"

module osd_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import osd_pkg::*;

    localparam int n_rand = 8;
    // bus cycles per test: sweep, write/read pairs, char pages, modes, pulses, controller
    localparam int bus_cycles = 22 + 6 * n_rand * 2 + 4 * 9 + 34 + 5 * 4
                                + 2 * (`RESET_HOLD_CYCLES + 7) + n_rand * 2;
    localparam int watchdog_ns = 2 * 20 * bus_cycles + 20 * 10;

    localparam logic [7:0] rw_regs [6] = '{`OSD_REG_OFFSET, `OSD_REG_ENABLE,
        `OSD_REG_HIGHLIGHT, `OSD_REG_SCAN_HI, `OSD_REG_SCAN_LO, `OSD_REG_RESET_CONF};

    logic                   clk;
    logic                   arst_n;
    logic [7:0]             addr;
    logic [7:0]             data_in;
    logic                   write_en;
    logic [7:0]             data_out;
    logic [`OSD_RAM_AW-1:0] osd_rd_addr;
    logic [7:0]             osd_rd_data;
    controller_data_t       controller_data;
    logic                   ram_wren;
    logic [`OSD_RAM_AW-1:0] ram_waddr;
    logic [7:0]             ram_wdata;
    logic                   enable_osd;
    logic [7:0]             highlight_line;
    logic [7:0]             reconf_data;
    scanline_t              scanline;
    logic [7:0]             reset_conf;
    video_config_t          video_config;
    logic                   reset_dc;
    logic                   reset_opt;

    // shadow of the register map, reset values
    logic [2:0] sh_offset = 3'd0;
    logic       sh_enable = 1'b0;
    logic [7:0] sh_highlight = 8'hff;
    logic [7:0] sh_reconf = 8'h00;
    logic [7:0] sh_scan_hi = 8'h80;
    logic [3:0] sh_scan_lo = 4'h0;
    logic [7:0] sh_reset_conf = 8'h00;
    logic [7:0] char_shadow [0:`OSD_RAM_DEPTH-1];

    logic [31:0] lfsr_state = 32'ha88f_a700;
    int          err_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    // read expectation travels one cycle behind the address
    logic        rd_req;
    logic [7:0]  rd_exp;
    logic        rd_chk;
    logic [7:0]  rd_chk_exp;

    osd_ctrl_top UUT (.*);

    bind osd_ctrl_top osd_ctrl_properties u_props (
        .clk(clk), .arst_n(arst_n), .addr(addr), .write_en(write_en), .data_out(data_out),
        .ram_wren(ram_wren), .reset_dc(reset_dc), .reset_opt(reset_opt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: run still busy after %0d ns", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [7:0] ref_read(input logic [7:0] a);
        case (a)
            `OSD_REG_OFFSET:     return {5'd0, sh_offset};
            `OSD_REG_ENABLE:     return {7'd0, sh_enable};
            `OSD_REG_HIGHLIGHT:  return sh_highlight;
            `OSD_REG_RECONF:     return sh_reconf;
            // a to right on top, start to default resolution below
            `OSD_REG_CTRL_HI:    return controller_data[12:5];
            `OSD_REG_CTRL_LO:    return {controller_data[4:0], 3'd0};
            `OSD_REG_SCAN_HI:    return sh_scan_hi;
            `OSD_REG_SCAN_LO:    return {sh_scan_lo, 4'd0};
            `OSD_REG_RESET_CONF: return sh_reset_conf;
            default:             return 8'h00;
        endcase
    endfunction

    function automatic scanline_t exp_scanline();
        scanline_t s;
        s.intensity = {sh_scan_hi, sh_scan_lo[3]};
        s.thickness = sh_scan_lo[2];
        s.oddeven   = sh_scan_lo[1];
        s.active    = sh_scan_lo[0];
        return s;
    endfunction

    function automatic video_config_t mode_for(input logic [3:0] idx);
        case (idx)
            4'd1:    return mode_960p;
            4'd2:    return mode_480p;
            4'd3:    return mode_vga;
            default: return mode_1080p;
        endcase
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_ram_addr(input string name, input logic [`OSD_RAM_AW-1:0] exp,
                                  input logic [`OSD_RAM_AW-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_scanline(input scanline_t exp, input scanline_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t scanline expected %h actual %h", $time, exp, act);
        end
    endtask

    task automatic check_video_config(input video_config_t exp, input video_config_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t video_config expected %h actual %h", $time, exp, act);
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_chk <= 1'b0;
        end else begin
            rd_chk     <= rd_req;
            rd_chk_exp <= rd_exp;
        end
    end

    // data_out settled by the falling edge
    always @(negedge clk) begin
        if (rd_chk) begin
            check_byte("data_out", rd_chk_exp, data_out);
        end
    end

    //////////////////////////////
    // bus tasks
    //////////////////////////////

    // every task starts and ends 1 ns after a rising edge
    task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
        addr     = a;
        data_in  = d;
        write_en = 1'b1;
        @(posedge clk);
        #1;
        write_en = 1'b0;
        if (a < `OSD_REG_OFFSET) begin
            char_shadow[{sh_offset, a[6:0]}] = d;
        end
        case (a)
            `OSD_REG_OFFSET:     sh_offset = d[2:0];
            `OSD_REG_ENABLE:     sh_enable = d[0];
            `OSD_REG_HIGHLIGHT:  sh_highlight = d;
            `OSD_REG_RECONF:     sh_reconf = d;
            `OSD_REG_SCAN_HI:    sh_scan_hi = d;
            `OSD_REG_SCAN_LO:    sh_scan_lo = d[7:4];
            `OSD_REG_RESET_CONF: sh_reset_conf = d;
            default: begin
            end
        endcase
    endtask

    task automatic bus_read(input logic [7:0] a);
        addr   = a;
        rd_req = 1'b1;
        rd_exp = ref_read(a);
        @(posedge clk);
        #1;
        rd_req = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        $display("test %0d %s done, %0d errors", test_count, name, err_count - errs_before);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic pulse_test(input logic [7:0] a, input logic dc_side);
        int   width;
        logic on_v;
        logic off_v;
        width = 0;
        bus_write(a, 8'h01);
        for (int i = 0; i < `RESET_HOLD_CYCLES + 6; i++) begin
            on_v  = dc_side ? reset_dc : reset_opt;
            off_v = dc_side ? reset_opt : reset_dc;
            if (on_v) begin
                width++;
            end
            check_bit("idle reset output", 1'b0, off_v);
            idle(1);
        end
        check_byte("reset pulse width", 8'(`RESET_HOLD_CYCLES), 8'(width));
    endtask

    task automatic char_ram_test();
        logic [31:0]            r;
        logic [`OSD_RAM_AW-1:0] waddr_q [$];
        for (int p = 0; p < 4; p++) begin
            // pages 1 4 7 2, each offset bit seen both ways
            bus_write(`OSD_REG_OFFSET, 8'(3 * p + 1));
            for (int i = 0; i < 8; i++) begin
                take_bits(15, r);
                bus_write({1'b0, r[14:8]}, r[7:0]);
                waddr_q.push_back({sh_offset, r[14:8]});
                // write port registered on the write edge
                check_bit("ram_wren", 1'b1, ram_wren);
                check_ram_addr("ram_waddr", waddr_q[$], ram_waddr);
                check_byte("ram_wdata", r[7:0], ram_wdata);
            end
        end
        // last write lands two edges later
        idle(2);
        foreach (waddr_q[k]) begin
            osd_rd_addr = waddr_q[k];
            idle(1);
            check_byte("osd_rd_data", char_shadow[waddr_q[k]], osd_rd_data);
        end
    endtask

    task automatic mode_test();
        logic [31:0]   r;
        video_config_t exp_mode;
        logic [3:0]    idx;
        exp_mode = mode_1080p;
        for (int i = 0; i < 4; i++) begin
            idx = 4'((i + 2) % 4);
            take_bits(4, r);
            bus_write(`OSD_REG_RECONF, {r[3:0], idx});
            check_byte("reconf_data", sh_reconf, reconf_data);
            // mode table still one stage behind
            check_video_config(exp_mode, video_config);
            exp_mode = mode_for(idx);
            idle(1);
            check_video_config(exp_mode, video_config);
            bus_read(`OSD_REG_RECONF);
        end
        bus_write(`OSD_REG_RECONF, 8'h05);
        check_byte("reconf_data", 8'h05, reconf_data);
        idle(2);
        check_video_config(exp_mode, video_config);
        bus_read(`OSD_REG_RECONF);
    endtask

    initial begin
        logic [31:0] r;
        int          errs;
        arst_n          = 1'b0;
        addr            = 8'h00;
        data_in         = 8'h00;
        write_en        = 1'b0;
        osd_rd_addr     = '0;
        controller_data = '0;
        rd_req          = 1'b0;
        rd_exp          = 8'h00;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle(1);

        errs = err_count;
        check_byte("data_out", 8'h00, data_out);
        for (int a = 'h80; a <= 'h8f; a++) begin
            bus_read(8'(a));
        end
        for (int a = 'hf0; a <= 'hf3; a++) begin
            bus_read(8'(a));
        end
        bus_read(8'h00);
        bus_read(8'h7f);
        check_scanline(exp_scanline(), scanline);
        check_video_config(mode_1080p, video_config);
        finish_test("reset values", errs);

        errs = err_count;
        foreach (rw_regs[k]) begin
            for (int i = 0; i < n_rand; i++) begin
                take_bits(8, r);
                bus_write(rw_regs[k], r[7:0]);
                check_scanline(exp_scanline(), scanline);
                check_byte("reset_conf", sh_reset_conf, reset_conf);
                check_byte("highlight_line", sh_highlight, highlight_line);
                check_bit("enable_osd", sh_enable, enable_osd);
                bus_read(rw_regs[k]);
            end
        end
        finish_test("register readback", errs);

        errs = err_count;
        char_ram_test();
        finish_test("character memory", errs);

        errs = err_count;
        mode_test();
        finish_test("mode switching", errs);

        errs = err_count;
        pulse_test(`OSD_REG_RESET_DC, 1'b1);
        pulse_test(`OSD_REG_RESET_OPT, 1'b0);
        finish_test("reset pulses", errs);

        errs = err_count;
        for (int i = 0; i < n_rand; i++) begin
            take_bits(13, r);
            controller_data = controller_data_t'(r[12:0]);
            bus_read(`OSD_REG_CTRL_HI);
            bus_read(`OSD_REG_CTRL_LO);
        end
        idle(2);
        finish_test("controller readback", errs);

        // bound assertion failures count as errors too
        err_count = err_count + UUT.u_props.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/osd_pkg.sv
hdl/osd_reg_file.sv
hdl/video_mode_rom.sv
hdl/osd_char_ram.sv
hdl/reset_pulse_gen.sv
hdl/osd_ctrl_top.sv
dv/osd_ctrl_properties.sv
dv/osd_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the OSD configuration subsystem

VERILATOR ?= verilator
TOP       ?= osd_ctrl_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

PASS_STR  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
